/* build.f */
+incdir+.
lcdPkg.sv
lcdStepRom.sv
lcdDelayTimer.sv
lcdNibbleWriter.sv
lcdSequencer.sv
lcdTop.sv
lcdTb.sv

/* lcdDelayTimer.sv */
module lcdDelayTimer #(
	parameter int powerOnCycles = 750000,
	parameter int wake1Cycles = 205000,
	parameter int wake2Cycles = 5000,
	parameter int cmdCycles = 2000,
	parameter int clearCycles = 82000,
	parameter int refreshCycles = 25000000
) (
	input logic Clock,
	input logic rst,
	input logic waitStart,
	input lcdPkg::lcdDelayT waitKind,
	output logic waitDone
);
	import lcdPkg::*;

	function automatic int maxOf(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	// counter sized by the longest wait, the refresh in practice
	localparam int maxCycles = maxOf(maxOf(maxOf(powerOnCycles, wake1Cycles),
		maxOf(wake2Cycles, cmdCycles)), maxOf(clearCycles, refreshCycles));
	localparam int countWidth = $clog2(maxCycles + 1);

	logic [countWidth-1:0] loadValue; // N-1 for the requested kind
	logic [countWidth-1:0] count;
	logic busy;

	// ------------------------------
	// kind to cycle count
	// ------------------------------
	always_comb
	begin
		case (waitKind)
			delayPowerOn: loadValue = countWidth'(powerOnCycles - 1);
			delayWake1: loadValue = countWidth'(wake1Cycles - 1);
			delayWake2: loadValue = countWidth'(wake2Cycles - 1);
			delayClear: loadValue = countWidth'(clearCycles - 1);
			delayRefresh: loadValue = countWidth'(refreshCycles - 1);
			default: loadValue = countWidth'(cmdCycles - 1); // delayCmd
		endcase
	end

	// done on the cycle the count reaches zero, N cycles after start
	assign waitDone = busy && (count == '0);

	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			count <= '0;
		end
		else if (waitStart)
		begin
			busy <= 1'b1;
			count <= loadValue;
		end
		else if (waitDone)
			busy <= 1'b0; // spent, go idle
		else if (busy)
			count <= count - 1'b1;
	end

	// sequencer only asks for a new wait once the previous one is spent
	assert property (@(posedge Clock) disable iff (rst) waitStart |-> !busy);

endmodule

/* lcdNibbleWriter.sv */
module lcdNibbleWriter #(
	parameter int pulseCycles = 12,
	parameter int nibbleGapCycles = 50
) (
	input logic Clock,
	input logic rst,
	input logic writeStart,
	input lcdPkg::lcdStepT step,
	output lcdPkg::lcdBusT lcdBus,
	output logic writeDone
);
	import lcdPkg::*;

	localparam int widthMax = (pulseCycles > nibbleGapCycles) ? pulseCycles : nibbleGapCycles;
	localparam int widthBits = $clog2(widthMax + 1);

	typedef enum logic [1:0] {
		idle,
		highPulse, // enable high, upper nibble
		gap, // enable low between nibbles
		lowPulse // enable high, lower nibble
	} phaseT;

	phaseT phase;
	logic [widthBits-1:0] widthCount; // cycles left in the current phase, minus one
	logic widthSpent;
	lcdStepT held; // step captured at start

	assign widthSpent = (widthCount == '0);

	// payload capture, only when a write is accepted
	always_ff @(posedge Clock)
	begin
		if (writeStart && (phase == idle))
			held <= step;
	end

	// ------------------------------
	// enable pulse shaping
	// ------------------------------
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			phase <= idle;
			widthCount <= '0;
			lcdBus <= '0;
			writeDone <= 1'b0;
		end
		else
		begin
			writeDone <= 1'b0; // one-cycle pulse
			case (phase)
				idle:
				begin
					if (writeStart)
					begin
						lcdBus.enable <= 1'b1; // rises one cycle after start
						lcdBus.regSel <= step.isData;
						lcdBus.data <= step.value[7:4]; // high nibble first
						widthCount <= widthBits'(pulseCycles - 1);
						phase <= highPulse;
					end
				end
				highPulse:
				begin
					if (widthSpent)
					begin
						lcdBus.enable <= 1'b0;
						if (held.singleNibble)
						begin
							writeDone <= 1'b1; // wake-up write ends here
							phase <= idle;
						end
						else
						begin
							widthCount <= widthBits'(nibbleGapCycles - 1);
							phase <= gap;
						end
					end
					else
						widthCount <= widthCount - 1'b1;
				end
				gap:
				begin
					if (widthSpent)
					begin
						lcdBus.enable <= 1'b1;
						lcdBus.regSel <= held.isData;
						lcdBus.data <= held.value[3:0];
						widthCount <= widthBits'(pulseCycles - 1);
						phase <= lowPulse;
					end
					else
						widthCount <= widthCount - 1'b1;
				end
				lowPulse:
				begin
					if (widthSpent)
					begin
						lcdBus.enable <= 1'b0; // data stays on the pins
						writeDone <= 1'b1;
						phase <= idle;
					end
					else
						widthCount <= widthCount - 1'b1;
				end
				default: phase <= idle;
			endcase
		end
	end

	// sequencer never overlaps writes
	assert property (@(posedge Clock) disable iff (rst) writeStart |-> phase == idle);
	// no stray enable once a write has finished
	assert property (@(posedge Clock) disable iff (rst) (phase == idle) |-> !lcdBus.enable);

endmodule

/* lcdPkg.sv */
package lcdPkg;

	// ------------------------------
	// LCD pins, 4-bit write-only bus
	// ------------------------------
	typedef struct packed {
		logic enable; // E, latched by the panel on the falling edge
		logic regSel; // 0 command, 1 data
		logic [3:0] data; // DB7..DB4
	} lcdBusT;

	// wait kinds, each maps to a cycle count inside the timer
	typedef enum logic [2:0] {
		delayPowerOn, // supply settle, 15 ms
		delayWake1, // after first 0x3, 4.1 ms
		delayWake2, // after second 0x3, 100 us
		delayCmd, // ordinary command or data, 40 us
		delayClear, // clear display is slow, 1.64 ms
		delayRefresh // idle time before the message is redrawn
	} lcdDelayT;

	// one entry of the step table
	typedef struct packed {
		logic isData; // drives regSel
		logic singleNibble; // wake-up writes send only value[7:4]
		logic [7:0] value;
		lcdDelayT waitKind; // wait after the last enable falls
	} lcdStepT;

	typedef logic [3:0] stepIndexT;

	// ------------------------------
	// step table layout
	// ------------------------------
	// 0..3 wake-up nibbles
	// 4..8 function set, entry mode, display on, clear, address
	// 9..  message characters
	localparam stepIndexT clearStep = 4'd7; // refresh loop re-enters here
	localparam stepIndexT firstMessageStep = 4'd9;
	localparam int messageLength = 4;
	localparam int stepCount = int'(firstMessageStep) + messageLength; // 13

	// text shown on line one, first character at index 0
	localparam logic [0:messageLength-1][7:0] lcdMessage = "Demo";

endpackage

/* lcdSequencer.sv */
module lcdSequencer (
	input logic Clock,
	input logic rst,
	input lcdPkg::lcdStepT step,
	input logic writeDone,
	input logic waitDone,
	output lcdPkg::stepIndexT stepIndex,
	output logic writeStart,
	output logic waitStart,
	output lcdPkg::lcdDelayT waitKind,
	output logic ready
);
	import lcdPkg::*;

	typedef enum logic [1:0] {
		powerOnWait, // supply settle after reset
		write, // nibble writer busy
		stepWait, // per-step wait running
		refreshWait // message on screen, idle until redraw
	} seqStateT;

	seqStateT state;
	logic launched; // power-on wait already requested
	logic lastStep;

	assign lastStep = (int'(stepIndex) == stepCount - 1);

	// ------------------------------
	// step walker
	// ------------------------------
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			state <= powerOnWait;
			launched <= 1'b0;
			stepIndex <= '0;
			writeStart <= 1'b0;
			waitStart <= 1'b0;
			waitKind <= delayPowerOn;
			ready <= 1'b0;
		end
		else
		begin
			// start and ready are single-cycle pulses
			writeStart <= 1'b0;
			waitStart <= 1'b0;
			ready <= 1'b0;
			case (state)
				powerOnWait:
				begin
					if (!launched)
					begin
						waitStart <= 1'b1; // first cycle out of reset
						waitKind <= delayPowerOn;
						launched <= 1'b1;
					end
					else if (waitDone)
					begin
						writeStart <= 1'b1; // step 0, first wake-up nibble
						state <= write;
					end
				end
				write:
				begin
					if (writeDone)
					begin
						waitStart <= 1'b1;
						waitKind <= step.waitKind; // table says how long
						state <= stepWait;
					end
				end
				stepWait:
				begin
					if (waitDone && lastStep)
					begin
						ready <= 1'b1; // message complete
						waitStart <= 1'b1;
						waitKind <= delayRefresh;
						stepIndex <= clearStep; // redraw starts with clear
						state <= refreshWait;
					end
					else if (waitDone)
					begin
						stepIndex <= stepIndex + 1'b1;
						writeStart <= 1'b1; // rom answers same cycle
						state <= write;
					end
				end
				refreshWait:
				begin
					if (waitDone)
					begin
						writeStart <= 1'b1;
						state <= write;
					end
				end
				default: state <= powerOnWait;
			endcase
		end
	end

	// table has only stepCount entries
	assert property (@(posedge Clock) disable iff (rst) int'(stepIndex) < stepCount);

endmodule

/* lcdStepRom.sv */
module lcdStepRom (
	input lcdPkg::stepIndexT stepIndex,
	output lcdPkg::lcdStepT step
);
	import lcdPkg::*;

	localparam int messageBits = $clog2(messageLength);

	stepIndexT messageIndex; // offset into lcdMessage

	// ------------------------------
	// entry builders
	// ------------------------------
	function automatic lcdStepT wakeStep(input logic [3:0] nibble, input lcdDelayT kind);
		// nibble rides in the upper half, lower half never sent
		return '{isData: 1'b0, singleNibble: 1'b1, value: {nibble, 4'h0}, waitKind: kind};
	endfunction

	function automatic lcdStepT cmdStep(input logic [7:0] code, input lcdDelayT kind);
		return '{isData: 1'b0, singleNibble: 1'b0, value: code, waitKind: kind};
	endfunction

	function automatic lcdStepT dataStep(input logic [7:0] character);
		return '{isData: 1'b1, singleNibble: 1'b0, value: character, waitKind: delayCmd};
	endfunction

	assign messageIndex = stepIndex - firstMessageStep;

	always_comb
	begin
		step = cmdStep(8'h00, delayCmd); // unused indices, never reached
		case (stepIndex)
			4'd0: step = wakeStep(4'h3, delayWake1); // 8-bit mode, first try
			4'd1: step = wakeStep(4'h3, delayWake2);
			4'd2: step = wakeStep(4'h3, delayCmd);
			4'd3: step = wakeStep(4'h2, delayCmd); // switch to 4-bit
			4'd4: step = cmdStep(8'h28, delayCmd); // function set, 2 lines 5x8
			4'd5: step = cmdStep(8'h06, delayCmd); // entry mode, increment no shift
			4'd6: step = cmdStep(8'h0C, delayCmd); // display on, cursor off
			clearStep: step = cmdStep(8'h01, delayClear); // clear display
			4'd8: step = cmdStep(8'h80, delayCmd); // DD RAM address 0
			default:
			begin
				// message characters
				if ((stepIndex >= firstMessageStep) && (int'(stepIndex) < stepCount))
					step = dataStep(lcdMessage[messageIndex[messageBits-1:0]]);
			end
		endcase
	end

endmodule

/* lcdTbChecks.svh */
`ifndef lcdTbChecksSvh
`define lcdTbChecksSvh

// ------------------------------
// result counters
// ------------------------------
int checkCount = 0;
int errorCount = 0;
int markChecks = 0; // totals at the end of the previous test
int markErrors = 0;

// pins against the expected nibble and regSel
task automatic checkBus(input string name, input lcdBusT got, input lcdBusT expected);
	checkCount++;
	if (got !== expected)
	begin
		errorCount++;
		$display("error %s expected %h got %h at %0t", name, expected, got, $time);
	end
endtask

// widths and gaps, exact when lo equals hi
task automatic checkCycles(input string name, input int got, input int lo, input int hi);
	checkCount++;
	if ((got < lo) || (got > hi))
	begin
		errorCount++;
		$display("error %s expected %h..%h got %h at %0t", name, lo, hi, got, $time);
	end
endtask

task automatic checkReady(input string name, input logic got, input logic expected);
	checkCount++;
	if (got !== expected)
	begin
		errorCount++;
		$display("error %s expected %h got %h at %0t", name, expected, got, $time);
	end
endtask

// one summary line per finished test
task automatic reportTest(input string name);
	$display("test %s: %0d checks, %0d errors", name, checkCount - markChecks,
		errorCount - markErrors);
	markChecks = checkCount;
	markErrors = errorCount;
endtask

`endif

/* lcdTb.sv */
module lcdTb;
	import lcdPkg::*;

	localparam int pulseCycles = 3;
	localparam int nibbleGapCycles = 4;
	localparam int powerOnCycles = 40;
	localparam int wake1Cycles = 30;
	localparam int wake2Cycles = 20;
	localparam int cmdCycles = 10;
	localparam int clearCycles = 25;
	localparam int refreshCycles = 60;
	localparam int slack = 20; // margin past the longest legal phase

	logic Clock;
	logic rst;
	lcdBusT lcdBus;
	logic ready;
	logic [31:0] lfsrState = 32'h1a32;
	lcdBusT modelBus[$]; // expected pins of each nibble in one pass
	int modelLo[$]; // shortest legal low time before that nibble
	int modelHi[$];
	int prevWait; // wait owed by the step modelled last
	int clearNibble; // first nibble of the clear command
	int holdOff;

	`include "lcdTbChecks.svh"

	lcdTop #(
		.pulseCycles(pulseCycles),
		.nibbleGapCycles(nibbleGapCycles),
		.powerOnCycles(powerOnCycles),
		.wake1Cycles(wake1Cycles),
		.wake2Cycles(wake2Cycles),
		.cmdCycles(cmdCycles),
		.clearCycles(clearCycles),
		.refreshCycles(refreshCycles)
	) u_dut (.Clock(Clock), .rst(rst), .lcdBus(lcdBus), .ready(ready));

	initial
	begin
		Clock = 1'b0;
		forever
			#5 Clock = ~Clock;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic int drawBits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = {lfsrState[30:0], ^(lfsrState & 32'h8020_0003)};
			value = (value << 1) | lfsrState[0];
		end
		return value;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$finish;
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	task automatic addStep(input logic [7:0] value, input logic isData, input logic single,
		input int waitCycles);
		modelBus.push_back({1'b1, isData, value[7:4]}); // high nibble first
		modelLo.push_back(prevWait);
		modelHi.push_back(prevWait + 3);
		if (!single)
		begin
			modelBus.push_back({1'b1, isData, value[3:0]});
			modelLo.push_back(nibbleGapCycles); // fixed gap inside a byte
			modelHi.push_back(nibbleGapCycles);
		end
		prevWait = waitCycles;
	endtask

	// pins and ready read 0 for all 10 reset cycles
	task automatic applyReset();
		rst = 1'b1;
		repeat (10)
		begin
			@(negedge Clock);
			checkBus("lcdBus", lcdBus, '0);
			checkReady("ready", ready, 1'b0);
		end
		rst = 1'b0;
	endtask

	// ------------------------------
	// bus monitor
	// ------------------------------
	// low time and one enable pulse, sampled on falling edges
	task automatic captureNibble(input lcdBusT expected, input int gapLo, input int gapHi,
		input int readyPulses, input bit fromReset);
		int lowCycles;
		int highCycles;
		int readyHits;
		lowCycles = 0;
		highCycles = 0;
		readyHits = 0;
		while (!lcdBus.enable)
		begin
			if (fromReset)
				checkBus("lcdBus", lcdBus, '0); // quiet until the first write
			readyHits += ready;
			lowCycles++;
			if (lowCycles > gapHi + slack)
				abortRun("timeout: no enable rise after the expected gap");
			@(negedge Clock);
		end
		while (lcdBus.enable)
		begin
			checkBus("lcdBus", lcdBus, expected); // value held all pulse long
			checkReady("ready", ready, 1'b0);
			highCycles++;
			if (highCycles > pulseCycles + slack)
				abortRun("timeout: enable stuck high");
			@(negedge Clock);
		end
		checkCycles("gapCycles", lowCycles, gapLo, gapHi);
		checkCycles("pulseCycles", highCycles, pulseCycles, pulseCycles);
		checkCycles("readyPulses", readyHits, readyPulses, readyPulses);
	endtask

	// first nibble gets its own gap bounds
	task automatic runPass(input int first, input int firstLo, input int firstHi,
		input int firstReady, input bit fromReset);
		captureNibble(modelBus[first], firstLo, firstHi, firstReady, fromReset);
		for (int i = first + 1; i < modelBus.size(); i++)
			captureNibble(modelBus[i], modelLo[i], modelHi[i], 0, 1'b0);
	endtask

	initial
	begin
		rst = 1'b1;
		prevWait = powerOnCycles;
		addStep(8'h30, 1'b0, 1'b1, wake1Cycles); // wake-up nibbles
		addStep(8'h30, 1'b0, 1'b1, wake2Cycles);
		addStep(8'h30, 1'b0, 1'b1, cmdCycles);
		addStep(8'h20, 1'b0, 1'b1, cmdCycles);
		addStep(8'h28, 1'b0, 1'b0, cmdCycles); // function set
		addStep(8'h06, 1'b0, 1'b0, cmdCycles);
		addStep(8'h0C, 1'b0, 1'b0, cmdCycles);
		clearNibble = modelBus.size();
		addStep(8'h01, 1'b0, 1'b0, clearCycles);
		addStep(8'h80, 1'b0, 1'b0, cmdCycles);
		for (int c = 0; c < messageLength; c++)
			addStep(lcdMessage[c], 1'b1, 1'b0, cmdCycles);
		applyReset();
		@(negedge Clock);
		runPass(0, modelLo[0], modelHi[0], 0, 1'b1);
		reportTest("init sequence, pulse shape and waits");
		// last data wait plus refresh, two extra hand-offs
		repeat (3)
			runPass(clearNibble, cmdCycles + refreshCycles,
				cmdCycles + refreshCycles + 6, 1, 1'b0);
		reportTest("refresh loop and ready");
		repeat (5)
		begin
			holdOff = drawBits(9); // up to 511 cycles into the run
			repeat (holdOff)
				@(negedge Clock);
			applyReset();
			@(negedge Clock);
			runPass(0, modelLo[0], modelHi[0], 0, 1'b1);
			reportTest($sformatf("reset after %0d cycles", holdOff));
		end
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* lcdTop.sv */
module lcdTop #(
	parameter int pulseCycles = 12, // 240 ns enable at 50 MHz
	parameter int nibbleGapCycles = 50, // 1 us between nibbles
	parameter int powerOnCycles = 750000,
	parameter int wake1Cycles = 205000,
	parameter int wake2Cycles = 5000,
	parameter int cmdCycles = 2000,
	parameter int clearCycles = 82000,
	parameter int refreshCycles = 25000000 // half a second
) (
	input logic Clock,
	input logic rst,
	output lcdPkg::lcdBusT lcdBus,
	output logic ready
);
	import lcdPkg::*;

	stepIndexT stepIndex;
	lcdStepT step; // current table entry
	logic writeStart;
	logic writeDone;
	logic waitStart;
	lcdDelayT waitKind;
	logic waitDone;

	// ------------------------------
	// control
	// ------------------------------
	lcdSequencer u_sequencer (
		.Clock(Clock),
		.rst(rst),
		.step(step),
		.writeDone(writeDone),
		.waitDone(waitDone),
		.stepIndex(stepIndex),
		.writeStart(writeStart),
		.waitStart(waitStart),
		.waitKind(waitKind),
		.ready(ready)
	);

	lcdStepRom u_stepRom (
		.stepIndex(stepIndex),
		.step(step)
	);

	// ------------------------------
	// timing blocks
	// ------------------------------
	lcdDelayTimer #(
		.powerOnCycles(powerOnCycles),
		.wake1Cycles(wake1Cycles),
		.wake2Cycles(wake2Cycles),
		.cmdCycles(cmdCycles),
		.clearCycles(clearCycles),
		.refreshCycles(refreshCycles)
	) u_delayTimer (
		.Clock(Clock),
		.rst(rst),
		.waitStart(waitStart),
		.waitKind(waitKind),
		.waitDone(waitDone)
	);

	lcdNibbleWriter #(
		.pulseCycles(pulseCycles),
		.nibbleGapCycles(nibbleGapCycles)
	) u_nibbleWriter (
		.Clock(Clock),
		.rst(rst),
		.writeStart(writeStart),
		.step(step),
		.lcdBus(lcdBus), // straight to the pins
		.writeDone(writeDone)
	);

endmodule
